/* include/roadf_defines.svh */
// --------------------
// address map, RAM size and frame timing macros
// include in any block that decodes or counts
// --------------------
`ifndef ROADF_DEFINES_SVH
`define ROADF_DEFINES_SVH

`define ROADF_RAM_AW        12          // 4 KB work RAM, upper 2 KB battery backed
`define ROADF_RAM_BASE      16'h3000    // RAM at 3000-3FFF

`define ROADF_IO_BASE       16'h1400    // 1 KB i/o window
`define ROADF_IO_AW         10
`define ROADF_IO_SEL_LSB    7           // 128 byte sub-blocks inside the window
`define ROADF_INTST_OFS     16'h0000    // obj frame toggle, read side effect
`define ROADF_IOW_OFS       16'h0080    // 8 bit addressable latch
`define ROADF_SND_OFS       16'h0100    // sound data strobe
`define ROADF_IN5_OFS       16'h0200    // dip bank b
`define ROADF_IOR_OFS       16'h0280    // cabinet inputs, 4 bytes

`define ROADF_FRAME_CYCLES  256         // short frame for simulation
`define ROADF_VBL_CYCLES    32          // blank at end of frame

`endif

/* hw/roadf_bus_pkg.sv */
// --------------------
// bus side types
// region decode result and AXI response codes
// --------------------
package roadf_bus_pkg;

    // decoded target of one internal access
    typedef enum logic [2:0] {
        NONE,   // unmapped, reads 0xff
        RAM,    // work ram incl. nvram half
        INTST,  // frame toggle
        IOW,    // control latch
        SND,    // sound byte
        IN5,    // dip b, read only
        IOR     // cabinet, read only
    } region_t;

    // only the two codes this slave ever returns
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

endpackage

/* hw/roadf_io_pkg.sv */
// --------------------
// cabinet side types
// joystick word, input byte select, latch bit map
// --------------------
package roadf_io_pkg;

    typedef struct packed {
        logic [2:0] buttons;    // bits 6-4
        logic       up;         // bit 3
        logic       down;
        logic       left;
        logic       right;      // bit 0
    } joy_t;

    typedef enum logic [1:0] {SYS, P1, P2, DSWA} cab_sel_t;

    // 74LS259 style latch, only three outputs wired
    typedef enum logic [2:0] {
        FLIP    = 3'd0,
        SND_IRQ = 3'd1,
        IRQ_EN  = 3'd7
    } latch_bit_t;

endpackage

/* hw/roadf_axil_fsm.sv */
// --------------------
// AXI4-Lite slave FSM
// one transaction in flight, each one becomes a
// single cycle internal access
// --------------------
`timescale 1ns/1ps

module roadf_axil_fsm
    import roadf_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [7:0]  wdata,
    input  logic        wvalid,
    output logic        wready,
    output axi_resp_t   bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [15:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [7:0]  rdata,
    output axi_resp_t   rresp,
    output logic        rvalid,
    input  logic        rready,
    output logic [15:0] acc_addr,
    output logic        acc_we,
    output logic        acc_re,
    output logic [7:0]  acc_wdata,
    input  logic        acc_err,
    input  logic [7:0]  rd_data
);

typedef enum logic [1:0] {IDLE, RD_WAIT, RD_RESP, WR_RESP} state_t;

state_t state;
logic   rd_go, wr_go;

assign rd_go = (state == IDLE) && arvalid;                      // reads win ties
assign wr_go = (state == IDLE) && !arvalid && awvalid && wvalid;

assign arready   = rd_go;
assign awready   = wr_go;   // aw and w taken together
assign wready    = wr_go;
assign acc_re    = rd_go;
assign acc_we    = wr_go;   // lands on the handshake edge
assign acc_addr  = rd_go ? araddr : awaddr;
assign acc_wdata = wdata;
assign rvalid    = (state == RD_RESP);
assign bvalid    = (state == WR_RESP);
assign rdata     = rd_data; // decoder holds it until the next read

always_ff @(posedge clk) begin
    if (rst) begin
        state <= IDLE;
        bresp <= OKAY;
        rresp <= OKAY;
    end else begin
        case (state)
            IDLE: begin
                if (rd_go) begin
                    state <= RD_WAIT;
                    rresp <= acc_err ? SLVERR : OKAY;
                end else if (wr_go) begin
                    state <= WR_RESP;
                    bresp <= acc_err ? SLVERR : OKAY;
                end
            end
            RD_WAIT: state <= RD_RESP;              // registered mux settles
            RD_RESP: if (rready) state <= IDLE;     // hold under back-pressure
            WR_RESP: if (bready) state <= IDLE;
            default: state <= IDLE;
        endcase
    end
end

endmodule

/* hw/roadf_addr_decode.sv */
// --------------------
// address decoder and read data mux
// gates write enables per region, flags bad writes,
// registers the read byte one cycle after the access
// --------------------
`timescale 1ns/1ps
`include "roadf_defines.svh"

module roadf_addr_decode
    import roadf_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] acc_addr,
    input  logic        acc_we,
    input  logic        acc_re,
    input  logic [7:0]  ram_dout,
    input  logic [7:0]  cab_byte,
    input  logic [7:0]  dipsw_b,
    output logic        acc_err,
    output logic        ram_we,
    output logic        iow_we,
    output logic        snd_we,
    output logic        intst_re,
    output logic [7:0]  rd_data
);

localparam logic [15:0] RAM_BASE = `ROADF_RAM_BASE;
localparam logic [15:0] IO_BASE  = `ROADF_IO_BASE;

region_t region, region_q;
logic    re_q;

// sub-block match inside the i/o window
function automatic logic io_hit(input logic [15:0] a, input logic [15:0] ofs);
    logic [15:0] blk;
    blk = IO_BASE + ofs;
    return a[15:`ROADF_IO_SEL_LSB] == blk[15:`ROADF_IO_SEL_LSB];
endfunction

always_comb begin
    region = NONE;
    if (acc_addr[15:`ROADF_RAM_AW] == RAM_BASE[15:`ROADF_RAM_AW]) region = RAM;
    else if (io_hit(acc_addr, `ROADF_INTST_OFS)) region = INTST;
    else if (io_hit(acc_addr, `ROADF_IOW_OFS))   region = IOW;
    else if (io_hit(acc_addr, `ROADF_SND_OFS))   region = SND;
    else if (io_hit(acc_addr, `ROADF_IN5_OFS))   region = IN5;
    else if (io_hit(acc_addr, `ROADF_IOR_OFS))   region = IOR;
end

assign ram_we   = acc_we && region == RAM;
assign iow_we   = acc_we && region == IOW;
assign snd_we   = acc_we && region == SND;
assign intst_re = acc_re && region == INTST;    // read has a side effect
assign acc_err  = acc_we && region inside {NONE, IN5, IOR};  // read-only or hole

always_ff @(posedge clk) begin
    if (rst) begin
        region_q <= NONE;
        re_q     <= 1'b0;
    end else begin
        region_q <= region;
        re_q     <= acc_re;
    end
end

// ram and cabinet bytes arrive one cycle after the access
always_ff @(posedge clk) begin
    if (re_q) begin
        case (region_q)
            RAM:     rd_data <= ram_dout;
            IOR:     rd_data <= cab_byte;
            IN5:     rd_data <= dipsw_b;
            default: rd_data <= 8'hff;  // open bus
        endcase
    end
end

endmodule

/* hw/roadf_cabinet_mux.sv */
// --------------------
// cabinet input formatter
// builds one of the four IOR bytes every clock,
// selected by the low address bits
// --------------------
`timescale 1ns/1ps

module roadf_cabinet_mux
    import roadf_io_pkg::*;
(
    input  logic       clk,
    input  cab_sel_t   sel,
    input  logic [1:0] start_button,
    input  logic [1:0] coin_input,
    input  logic       service,
    input  joy_t       joystick1,
    input  joy_t       joystick2,
    input  logic [7:0] dipsw_a,
    input  logic [2:0] dipsw_c,
    output logic [7:0] cab_byte
);

// board order: down and up swapped against the joystick word,
// right ahead of left
function automatic logic [7:0] fmt_joy(input joy_t j);
    return {1'b1, j.buttons, j.down, j.up, j.right, j.left};
endfunction

always_ff @(posedge clk) begin
    case (sel)
        SYS:     cab_byte <= {dipsw_c, start_button, service, coin_input}; // jumpers on top
        P1:      cab_byte <= fmt_joy(joystick1);
        P2:      cab_byte <= fmt_joy(joystick2);
        DSWA:    cab_byte <= dipsw_a;
        default: cab_byte <= 8'hff;
    endcase
end

endmodule

/* hw/roadf_ctrl_latch.sv */
// --------------------
// control latch, sound strobe and obj frame toggle
// latch takes data bit 0 into the bit picked by addr[2:0]
// --------------------
`timescale 1ns/1ps

module roadf_ctrl_latch
    import roadf_io_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       iow_we,
    input  logic       snd_we,
    input  logic       intst_re,
    input  logic [2:0] acc_addr,
    input  logic [7:0] acc_wdata,
    output logic       flip,
    output logic       snd_irq,
    output logic       irq_en,
    output logic [7:0] snd_data,
    output logic       snd_data_cs,
    output logic       obj_frame
);

logic intst_l;  // last cycle was an intst read

always_ff @(posedge clk) begin
    if (rst) begin
        flip        <= 1'b0;
        snd_irq     <= 1'b0;
        irq_en      <= 1'b0;
        snd_data_cs <= 1'b0;
        obj_frame   <= 1'b0;
        intst_l     <= 1'b0;
    end else begin
        snd_data_cs <= snd_we;      // one clock pulse
        intst_l     <= intst_re;
        if (intst_re && !intst_l) obj_frame <= ~obj_frame;
        if (iow_we) begin
            case (latch_bit_t'(acc_addr))
                FLIP:    flip    <= acc_wdata[0];
                SND_IRQ: snd_irq <= acc_wdata[0];
                IRQ_EN:  irq_en  <= acc_wdata[0];   // 0 also clears pending irq
                default: ;                          // coin counters etc, not wired
            endcase
        end
    end
end

always_ff @(posedge clk) begin
    if (snd_we) snd_data <= acc_wdata;  // sound cpu reads it later
end

endmodule

/* hw/roadf_vbl_timer.sv */
// --------------------
// frame counter with vertical blank
// irq latches on blank start, cleared while irq_en low
// --------------------
`timescale 1ns/1ps
`include "roadf_defines.svh"

module roadf_vbl_timer (
    input  logic clk,
    input  logic rst,
    input  logic irq_en,
    input  logic dip_pause,
    output logic vbl,
    output logic irq
);

localparam int CW        = $clog2(`ROADF_FRAME_CYCLES);
localparam int VBL_START = `ROADF_FRAME_CYCLES - `ROADF_VBL_CYCLES;

logic [CW-1:0] cnt;
logic          vbl_l;   // previous blank, for edge
logic          irq_q;

assign vbl = (cnt >= CW'(VBL_START));   // last lines of the frame
assign irq = irq_q & irq_en;            // drops as soon as enable goes

always_ff @(posedge clk) begin
    if (rst) begin
        cnt <= '0;
    end else if (cnt == CW'(`ROADF_FRAME_CYCLES - 1)) begin
        cnt <= '0;
    end else begin
        cnt <= cnt + 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        vbl_l <= 1'b0;
        irq_q <= 1'b0;
    end else begin
        vbl_l <= vbl;
        if (!irq_en)
            irq_q <= 1'b0;      // clear through the latch
        else if (vbl && !vbl_l && dip_pause)
            irq_q <= 1'b1;      // pause switch low blocks it
    end
end

endmodule

/* hw/roadf_work_ram.sv */
// --------------------
// synchronous byte RAM
// work RAM plus battery backed half, read returns
// the old byte when written in the same cycle
// --------------------
`timescale 1ns/1ps
`include "roadf_defines.svh"

module roadf_work_ram (
    input  logic                     clk,
    input  logic                     we,
    input  logic [`ROADF_RAM_AW-1:0] addr,
    input  logic [7:0]               din,
    output logic [7:0]               dout
);

logic [7:0] mem [0:(1<<`ROADF_RAM_AW)-1];

always_ff @(posedge clk) begin
    if (we) mem[addr] <= din;
    dout <= mem[addr];  // read before write
end

endmodule

/* hw/roadf_main.sv */
// --------------------
// main board glue top level
// AXI4-Lite slave in place of the cpu bus,
// cabinet and sound side as plain ports
// --------------------
`timescale 1ns/1ps
`include "roadf_defines.svh"

module roadf_main
    import roadf_bus_pkg::*;
    import roadf_io_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [7:0]  wdata,
    input  logic        wvalid,
    output logic        wready,
    output axi_resp_t   bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [15:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [7:0]  rdata,
    output axi_resp_t   rresp,
    output logic        rvalid,
    input  logic        rready,
    input  logic [1:0]  start_button,
    input  logic [1:0]  coin_input,
    input  logic        service,
    input  joy_t        joystick1,
    input  joy_t        joystick2,
    input  logic [7:0]  dipsw_a,
    input  logic [7:0]  dipsw_b,
    input  logic [2:0]  dipsw_c,    // board jumpers
    input  logic        dip_pause,
    output logic        flip,
    output logic        snd_irq,
    output logic [7:0]  snd_data,
    output logic        snd_data_cs,
    output logic        obj_frame,
    output logic        vbl,
    output logic        irq
);

logic [15:0] acc_addr;
logic [7:0]  acc_wdata, rd_data, ram_dout, cab_byte;
logic        acc_we, acc_re, acc_err;
logic        ram_we, iow_we, snd_we, intst_re;
logic        irq_en;

roadf_axil_fsm u_fsm (
    .clk(clk), .rst(rst),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .acc_addr(acc_addr), .acc_we(acc_we), .acc_re(acc_re), .acc_wdata(acc_wdata),
    .acc_err(acc_err), .rd_data(rd_data)
);

roadf_addr_decode u_dec (
    .clk(clk), .rst(rst),
    .acc_addr(acc_addr), .acc_we(acc_we), .acc_re(acc_re),
    .ram_dout(ram_dout), .cab_byte(cab_byte), .dipsw_b(dipsw_b),
    .acc_err(acc_err), .ram_we(ram_we), .iow_we(iow_we), .snd_we(snd_we),
    .intst_re(intst_re), .rd_data(rd_data)
);

roadf_work_ram u_ram (
    .clk(clk), .we(ram_we),
    .addr(acc_addr[`ROADF_RAM_AW-1:0]),
    .din(acc_wdata), .dout(ram_dout)
);

roadf_cabinet_mux u_cab (
    .clk(clk), .sel(cab_sel_t'(acc_addr[1:0])),     // IOR +0..+3
    .start_button(start_button), .coin_input(coin_input), .service(service),
    .joystick1(joystick1), .joystick2(joystick2),
    .dipsw_a(dipsw_a), .dipsw_c(dipsw_c), .cab_byte(cab_byte)
);

roadf_ctrl_latch u_latch (
    .clk(clk), .rst(rst),
    .iow_we(iow_we), .snd_we(snd_we), .intst_re(intst_re),
    .acc_addr(acc_addr[2:0]), .acc_wdata(acc_wdata),
    .flip(flip), .snd_irq(snd_irq), .irq_en(irq_en),
    .snd_data(snd_data), .snd_data_cs(snd_data_cs), .obj_frame(obj_frame)
);

roadf_vbl_timer u_vbl (
    .clk(clk), .rst(rst),
    .irq_en(irq_en), .dip_pause(dip_pause),
    .vbl(vbl), .irq(irq)
);

endmodule

/* bench/roadf_main_assert.sv */
// --------------------
// bus handshake and interrupt properties
// bound into the top level, fires $error on violation
// --------------------
`timescale 1ns/1ps

module roadf_main_assert
    import roadf_bus_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       arvalid,
    input logic       arready,
    input logic       rvalid,
    input logic       rready,
    input logic [7:0] rdata,
    input axi_resp_t  rresp,
    input logic       bvalid,
    input logic       bready,
    input axi_resp_t  bresp,
    input logic       vbl,
    input logic       dip_pause,
    input logic       irq,
    input logic       irq_en
);

int fails = 0;  // failed assertions so far

// response held until the master takes it
a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
        $error("read response changed before rready");
        fails++;
    end

a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
        $error("write response changed before bready");
        fails++;
    end

// access cycle, then mux cycle
a_rd_latency: assert property (@(posedge clk) disable iff (rst)
    arvalid && arready |=> !rvalid ##1 rvalid)
    else begin
        $error("rvalid not two cycles after the AR handshake");
        fails++;
    end

// irq only rises the cycle after blank starts, enable and pause both high
a_irq_set: assert property (@(posedge clk) disable iff (rst)
    $rose(irq) |-> $past(vbl) && !$past(vbl, 2) && $past(irq_en) && $past(dip_pause))
    else begin
        $error("irq rose outside a blank start with irq_en and dip_pause high");
        fails++;
    end

endmodule

bind roadf_main roadf_main_assert u_assert (
    .clk(clk), .rst(rst),
    .arvalid(arvalid), .arready(arready),
    .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
    .bvalid(bvalid), .bready(bready), .bresp(bresp),
    .vbl(vbl), .dip_pause(dip_pause),
    .irq(irq), .irq_en(irq_en)
);

/* bench/roadf_main_tb.sv */
// --------------------
// directed testbench for the main board glue
// AXI master tasks, one task per test, error count
// and a cycle watchdog
// --------------------
`timescale 1ns/1ps
`include "roadf_defines.svh"

module roadf_main_tb
    import roadf_bus_pkg::*;
    import roadf_io_pkg::*;
;

localparam logic [15:0] RAM_ADDR   = `ROADF_RAM_BASE;
localparam logic [15:0] INTST_ADDR = `ROADF_IO_BASE + `ROADF_INTST_OFS;
localparam logic [15:0] IOW_ADDR   = `ROADF_IO_BASE + `ROADF_IOW_OFS;
localparam logic [15:0] SND_ADDR   = `ROADF_IO_BASE + `ROADF_SND_OFS;
localparam logic [15:0] IN5_ADDR   = `ROADF_IO_BASE + `ROADF_IN5_OFS;
localparam logic [15:0] IOR_ADDR   = `ROADF_IO_BASE + `ROADF_IOR_OFS;
localparam logic [15:0] HOLE_ADDR  = 16'h8000;  // nothing decodes here
localparam int FRAME     = `ROADF_FRAME_CYCLES;
localparam int MAX_STALL = 7;
localparam int N_TRANS   = 140;                 // all bus transactions, rounded up
// every transaction at worst, plus frames waited on and two spare
localparam int LIMIT     = N_TRANS * (MAX_STALL + 6) + 6 * FRAME + 10;

logic        clk = 1'b0;
logic        rst;
logic [15:0] awaddr, araddr;
logic        awvalid, wvalid, bready, arvalid, rready;
logic        awready, wready, bvalid, arready, rvalid;
logic [7:0]  wdata, rdata;
axi_resp_t   bresp, rresp;
logic [1:0]  start_button, coin_input;
logic        service, dip_pause;
joy_t        joystick1, joystick2;
logic [7:0]  dipsw_a, dipsw_b;
logic [2:0]  dipsw_c;
logic        flip, snd_irq, snd_data_cs, obj_frame, vbl, irq;
logic [7:0]  snd_data;

integer      seed;
int          errors = 0;
int          checks = 0;
int          snd_pulses = 0;
int          cycle_count;
string       test_name = "reset";
logic [7:0]  ram_model [0:(1<<`ROADF_RAM_AW)-1];

roadf_main UUT (.*);

always #10 clk = ~clk;  // 20 ns

always @(posedge clk) if (snd_data_cs === 1'b1) snd_pulses++;   // strobe counter

initial begin
    cycle_count = 0;
    while (cycle_count < LIMIT) begin
        @(posedge clk);
        cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", LIMIT);
    $display(">>> FAIL");
    $finish;
end

task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    if (act !== exp) begin
        $display("mismatch %s/%s: expected %h, got %h", test_name, what, exp, act);
        errors++;
    end
endtask

task automatic check_resp(input string what, input axi_resp_t exp, input axi_resp_t act);
    checks++;
    if (act !== exp) begin
        $display("mismatch %s/%s: expected %s, got %s", test_name, what, exp.name(), act.name());
        errors++;
    end
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
        $display("mismatch %s/%s: expected %b, got %b", test_name, what, exp, act);
        errors++;
    end
endtask

// stall = cycles bready stays low once bvalid is up
task automatic axil_write(input logic [15:0] addr, input logic [7:0] data,
                          input int stall, output axi_resp_t resp);
    @(negedge clk);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    do @(posedge clk); while (!(awready && wready));    // pre-edge values
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) @(negedge clk);
    resp = bresp;
    repeat (stall) begin
        @(negedge clk);
        if (!bvalid || bresp !== resp) begin
            $display("%s: write response dropped or changed while bready low", test_name);
            errors++;
        end
    end
    bready = 1'b1;
    @(posedge clk);     // B handshake
    @(negedge clk);
    bready = 1'b0;
endtask

task automatic axil_read(input logic [15:0] addr, input int stall,
                         output logic [7:0] data, output axi_resp_t resp);
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    do @(posedge clk); while (!arready);
    @(negedge clk);
    arvalid = 1'b0;
    while (!rvalid) @(negedge clk);
    data = rdata;
    resp = rresp;
    repeat (stall) begin
        @(negedge clk);
        if (!rvalid || rdata !== data || rresp !== resp) begin
            $display("%s: read response dropped or changed while rready low", test_name);
            errors++;
        end
    end
    rready = 1'b1;
    @(posedge clk);     // R handshake
    @(negedge clk);
    rready = 1'b0;
endtask

function automatic int rand_stall();
    return 1 + (($random(seed) & 32'h7fff_ffff) % MAX_STALL);
endfunction

// player byte: 1, buttons 6-4, down, up, right, left
function automatic logic [7:0] player_byte(input logic [6:0] j);
    return {1'b1, j[6:4], j[2], j[3], j[0], j[1]};
endfunction

task automatic test_reset_state();
    test_name = "reset";
    check_bit("awready", 1'b0, awready);
    check_bit("arready", 1'b0, arready);
    check_bit("bvalid", 1'b0, bvalid);
    check_bit("rvalid", 1'b0, rvalid);
    check_bit("flip", 1'b0, flip);
    check_bit("snd_irq", 1'b0, snd_irq);
    check_bit("obj_frame", 1'b0, obj_frame);
    check_bit("irq", 1'b0, irq);
    check_bit("snd_data_cs", 1'b0, snd_data_cs);
endtask

task automatic test_ram();
    int         addr_list [32];
    logic [7:0] d;
    axi_resp_t  resp;
    test_name = "ram";
    for (int i = 0; i < 32; i++) begin
        addr_list[i] = $random(seed) & 12'hfff;     // whole 4 KB incl. nvram half
        d = $random(seed);
        ram_model[addr_list[i]] = d;
        axil_write(RAM_ADDR + addr_list[i], d, 0, resp);
        check_resp("write resp", OKAY, resp);
    end
    for (int i = 0; i < 32; i++) begin
        axil_read(RAM_ADDR + addr_list[i], 0, d, resp);
        check_byte($sformatf("ram[%h]", addr_list[i]), ram_model[addr_list[i]], d);
        check_resp("read resp", OKAY, resp);
    end
endtask

task automatic test_cabinet();
    logic [7:0] d;
    axi_resp_t  resp;
    test_name = "cabinet";
    repeat (3) begin
        @(negedge clk);
        start_button = $random(seed);
        coin_input   = $random(seed);
        service      = $random(seed);
        joystick1    = joy_t'($random(seed));
        joystick2    = joy_t'($random(seed));
        dipsw_a      = $random(seed);
        dipsw_b      = $random(seed);
        dipsw_c      = $random(seed);
        axil_read(IOR_ADDR + 16'd0, 0, d, resp);
        check_byte("sys", {dipsw_c, start_button, service, coin_input}, d);
        check_resp("sys resp", OKAY, resp);
        axil_read(IOR_ADDR + 16'd1, 0, d, resp);
        check_byte("p1", player_byte(joystick1), d);
        axil_read(IOR_ADDR + 16'd2, 0, d, resp);
        check_byte("p2", player_byte(joystick2), d);
        axil_read(IOR_ADDR + 16'd3, 0, d, resp);
        check_byte("dsw a", dipsw_a, d);
        axil_read(IN5_ADDR, 0, d, resp);
        check_byte("dsw b", dipsw_b, d);
    end
    axil_read(HOLE_ADDR, 0, d, resp);
    check_byte("open bus", 8'hff, d);
    check_resp("open bus resp", OKAY, resp);
    axil_write(IOR_ADDR, 8'h5a, 0, resp);
    check_resp("ior write", SLVERR, resp);
    axil_write(IN5_ADDR, 8'h5a, 0, resp);
    check_resp("in5 write", SLVERR, resp);
    axil_write(HOLE_ADDR, 8'h5a, 0, resp);
    check_resp("hole write", SLVERR, resp);
endtask

task automatic test_latch();
    axi_resp_t resp;
    test_name = "latch";
    for (int i = 2; i < 7; i++) axil_write(IOW_ADDR + i, 8'h01, 0, resp);  // unwired
    check_bit("flip idle", 1'b0, flip);
    check_bit("snd_irq idle", 1'b0, snd_irq);
    axil_write(IOW_ADDR + 16'd0, 8'h01, 0, resp);
    check_resp("latch resp", OKAY, resp);
    check_bit("flip set", 1'b1, flip);
    check_bit("snd_irq untouched", 1'b0, snd_irq);
    axil_write(IOW_ADDR + 16'd1, 8'hff, 0, resp);
    check_bit("snd_irq set", 1'b1, snd_irq);
    for (int i = 2; i < 7; i++) axil_write(IOW_ADDR + i, 8'h00, 0, resp);
    check_bit("flip kept", 1'b1, flip);
    check_bit("snd_irq kept", 1'b1, snd_irq);
    axil_write(IOW_ADDR + 16'd0, 8'hfe, 0, resp);   // only data bit 0 counts
    check_bit("flip clear", 1'b0, flip);
    axil_write(IOW_ADDR + 16'd1, 8'h00, 0, resp);
    check_bit("snd_irq clear", 1'b0, snd_irq);
endtask

task automatic test_sound_frame();
    logic [7:0] d, b;
    logic       frame0;
    axi_resp_t  resp;
    test_name = "sound";
    b = $random(seed);
    snd_pulses = 0;
    axil_write(SND_ADDR, b, 2, resp);
    repeat (3) @(negedge clk);
    check_resp("snd resp", OKAY, resp);
    check_byte("snd_data", b, snd_data);
    check_byte("strobe count", 8'd1, 8'(snd_pulses));
    test_name = "frame toggle";
    frame0 = obj_frame;
    axil_read(INTST_ADDR, 0, d, resp);
    check_bit("first read", ~frame0, obj_frame);
    check_byte("intst data", 8'hff, d);
    axil_read(INTST_ADDR, 0, d, resp);
    check_bit("second read", frame0, obj_frame);
endtask

task automatic test_interrupt();
    axi_resp_t resp;
    int        rises;
    int        blank;
    logic      vbl_prev;
    test_name = "interrupt";
    @(negedge clk);
    dip_pause = 1'b1;
    axil_write(IOW_ADDR + 16'd7, 8'h01, 0, resp);   // irq_en
    check_resp("irq_en resp", OKAY, resp);
    while (vbl) @(negedge clk);
    while (!vbl) @(negedge clk);                    // first cycle of blank
    check_bit("irq at blank start", 1'b0, irq);
    blank = 1;
    @(negedge clk);
    check_bit("irq after blank start", 1'b1, irq);
    while (vbl) begin
        blank++;
        @(negedge clk);
    end
    check_byte("blank length", 8'(`ROADF_VBL_CYCLES), 8'(blank));
    check_bit("irq level past blank", 1'b1, irq);
    axil_write(IOW_ADDR + 16'd7, 8'h00, 0, resp);
    check_bit("irq after clear", 1'b0, irq);
    test_name = "pause";
    dip_pause = 1'b0;
    axil_write(IOW_ADDR + 16'd7, 8'h01, 0, resp);
    rises    = 0;
    vbl_prev = vbl;
    repeat (FRAME + 8) begin                        // a full frame, one blank start
        @(negedge clk);
        if (vbl && !vbl_prev) rises++;
        vbl_prev = vbl;
        if (irq) begin
            $display("%s: irq raised while the pause switch is low", test_name);
            errors++;
        end
    end
    if (rises == 0) begin
        $display("%s: no vertical blank seen within a frame", test_name);
        errors++;
    end
    axil_write(IOW_ADDR + 16'd7, 8'h00, 0, resp);
    dip_pause = 1'b1;
endtask

task automatic test_backpressure();
    logic [11:0] a;
    logic [7:0]  d;
    axi_resp_t   resp;
    test_name = "backpressure";
    repeat (8) begin
        a = $random(seed);
        d = $random(seed);
        ram_model[a] = d;
        axil_write(RAM_ADDR + a, d, rand_stall(), resp);
        check_resp("write resp", OKAY, resp);
        axil_read(RAM_ADDR + a, rand_stall(), d, resp);
        check_byte($sformatf("ram[%h]", a), ram_model[a], d);
        check_resp("read resp", OKAY, resp);
    end
endtask

initial begin
    seed         = 90657;
    rst          = 1'b1;
    awaddr       = '0;
    awvalid      = 1'b0;
    wdata        = '0;
    wvalid       = 1'b0;
    bready       = 1'b0;
    araddr       = '0;
    arvalid      = 1'b0;
    rready       = 1'b0;
    start_button = '0;
    coin_input   = '0;
    service      = 1'b0;
    joystick1    = '0;
    joystick2    = '0;
    dipsw_a      = '0;
    dipsw_b      = '0;
    dipsw_c      = '0;
    dip_pause    = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_reset_state();
    test_ram();
    test_cabinet();
    test_latch();
    test_sound_frame();
    test_interrupt();
    test_backpressure();
    $display("checks %0d, errors %0d, assertion failures %0d",
             checks, errors, UUT.u_assert.fails);
    if (errors == 0 && UUT.u_assert.fails == 0)
        $display(">>> PASS");
    else
        $display(">>> FAIL");
    $finish;
end

endmodule

/* project.f */
+incdir+include
hw/roadf_bus_pkg.sv
hw/roadf_io_pkg.sv
hw/roadf_axil_fsm.sv
hw/roadf_addr_decode.sv
hw/roadf_cabinet_mux.sv
hw/roadf_ctrl_latch.sv
hw/roadf_vbl_timer.sv
hw/roadf_work_ram.sv
hw/roadf_main.sv
bench/roadf_main_assert.sv
bench/roadf_main_tb.sv

/* Bender.yml */
package:
  name: roadf_main

sources:
  - include_dirs:
      - include
    files:
      - hw/roadf_bus_pkg.sv
      - hw/roadf_io_pkg.sv
      - hw/roadf_axil_fsm.sv
      - hw/roadf_addr_decode.sv
      - hw/roadf_cabinet_mux.sv
      - hw/roadf_ctrl_latch.sv
      - hw/roadf_vbl_timer.sv
      - hw/roadf_work_ram.sv
      - hw/roadf_main.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/roadf_main_assert.sv
      - bench/roadf_main_tb.sv
